/* verilog/rf_pkg.sv */
package rf_pkg;

	// copies per architectural register
	localparam int rp = 4;
	// copy index width is log2 of rp
	localparam int rb = 2;
	// alu, bru, lsu, csr, mul
	localparam int num_wb = 5;
	// architectural registers x0..x31
	localparam int num_arch = 32;
	// physical copies in total
	localparam int num_phy = num_arch * rp;

	// unit slots in the packed write-back arrays
	localparam int unit_alu = 0;
	localparam int unit_bru = 1;
	localparam int unit_lsu = 2;
	localparam int unit_csr = 3;
	localparam int unit_mul = 4;

	// architectural register number
	typedef logic [4:0] arch_t;
	// copy index inside one register
	typedef logic [rb-1:0] copy_t;
	// physical tag laid out as {arch, copy}
	typedef logic [6:0] tag_t;
	// register data
	typedef logic [63:0] xlen_t;
	// outstanding renames of one register up to rp-1
	typedef logic [2:0] cnt_t;
	// one bit per physical copy
	typedef logic [num_phy-1:0] phy_mask_t;

	// the rp copies of x0 sit at the bottom of every mask
	localparam phy_mask_t x0_mask = phy_mask_t'((1 << rp) - 1);

endpackage

/* verilog/rename_if.sv */
`timescale 1ns/100ps

interface rename_if;

	// rename accepted this cycle
	logic         rn_fire;
	// copy handed out by the rename
	rf_pkg::tag_t rn_tag;
	// commit retired one copy this cycle
	logic         cm_fire;
	// copy that is now the architectural one
	rf_pkg::tag_t cm_tag;

	// rename table side
	modport source (
		output rn_fire,
		output rn_tag,
		output cm_fire,
		output cm_tag
	);

	// write-back log side
	modport sink (
		input rn_fire,
		input rn_tag,
		input cm_fire,
		input cm_tag
	);

endinterface

/* verilog/rename_table.sv */
`timescale 1ns/100ps

module rename_table (
	input  logic          clk,
	input  logic          arst_n,
	// rename request
	input  logic          rn_req,
	input  rf_pkg::arch_t rn_arch,
	output logic          rn_ready,
	output rf_pkg::tag_t  rn_tag,
	// commit of the oldest outstanding copy
	input  logic          cm_valid,
	input  rf_pkg::arch_t cm_arch,
	// read port lookup
	input  rf_pkg::arch_t rd_arch,
	output rf_pkg::tag_t  rd_tag,
	// events toward the write-back log
	rename_if.source      ev
);

	// newest copy of each register
	rf_pkg::copy_t rename_ptr [rf_pkg::num_arch];
	// architectural copy of each register
	rf_pkg::copy_t commit_ptr [rf_pkg::num_arch];
	// renames not yet committed
	rf_pkg::cnt_t  count      [rf_pkg::num_arch];

	logic          rn_zero;
	rf_pkg::copy_t rn_next;
	rf_pkg::copy_t rn_copy;
	rf_pkg::copy_t cm_next;
	logic          rn_fire;
	logic          cm_fire;
	// one-hot register select for each event
	logic [rf_pkg::num_arch-1:0] rn_hit;
	logic [rf_pkg::num_arch-1:0] cm_hit;

	assign rn_zero = (rn_arch == '0);

	// next copy wraps modulo rp through the copy_t width
	assign rn_next = rename_ptr[rn_arch] + 1'b1;
	assign cm_next = commit_ptr[cm_arch] + 1'b1;

	// x0 never allocates, so always ready
	assign rn_ready = rn_zero || (count[rn_arch] < rf_pkg::cnt_t'(rf_pkg::rp - 1));

	// x0 shows copy 0
	assign rn_copy = rn_zero ? '0 : rn_next;
	assign rn_tag = {rn_arch, rn_copy};

	// request without ready is dropped
	assign rn_fire = rn_req && rn_ready && !rn_zero;
	// commit with nothing outstanding is ignored
	assign cm_fire = cm_valid && (count[cm_arch] != '0);

	assign rn_hit = {{(rf_pkg::num_arch - 1){1'b0}}, rn_fire} << rn_arch;
	assign cm_hit = {{(rf_pkg::num_arch - 1){1'b0}}, cm_fire} << cm_arch;

	assign ev.rn_fire = rn_fire;
	assign ev.rn_tag = {rn_arch, rn_next};
	assign ev.cm_fire = cm_fire;
	assign ev.cm_tag = {cm_arch, cm_next};

	// newest copy for the read port
	assign rd_tag = {rd_arch, rename_ptr[rd_arch]};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < rf_pkg::num_arch; i++) begin
				rename_ptr[i] <= '0;
				commit_ptr[i] <= '0;
				count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < rf_pkg::num_arch; i++) begin
				if (rn_hit[i]) begin
					rename_ptr[i] <= rename_ptr[i] + 1'b1;
				end
				if (cm_hit[i]) begin
					commit_ptr[i] <= commit_ptr[i] + 1'b1;
				end
				// rename and commit together leave the count alone
				case ({rn_hit[i], cm_hit[i]})
					2'b10: count[i] <= count[i] + 1'b1;
					2'b01: count[i] <= count[i] - 1'b1;
					default: count[i] <= count[i];
				endcase
			end
		end
	end

endmodule

/* verilog/write_back.sv */
`timescale 1ns/100ps

module write_back (
	// unit results, indexed by unit number
	input  logic          wb_valid [rf_pkg::num_wb],
	input  rf_pkg::tag_t  wb_tag   [rf_pkg::num_wb],
	input  rf_pkg::xlen_t wb_res   [rf_pkg::num_wb],
	// current register-file image
	input  rf_pkg::xlen_t qout     [rf_pkg::num_phy],
	// next register-file image
	output rf_pkg::xlen_t dnxt     [rf_pkg::num_phy],
	// copies written this cycle
	output rf_pkg::phy_mask_t writeb_set
);

	rf_pkg::phy_mask_t set_all;

	// x0 copies hold zero whatever is written to them
	for (genvar sel = 0; sel < rf_pkg::rp; sel++) begin : g_x0
		assign dnxt[sel] = '0;
	end

	// one merge per copy above x0
	for (genvar sel = rf_pkg::rp; sel < rf_pkg::num_phy; sel++) begin : g_copy
		logic          hit;
		rf_pkg::xlen_t merged;

		always_comb begin
			hit = 1'b0;
			merged = '0;
			// units never share a tag, so OR is a clean select
			for (int u = 0; u < rf_pkg::num_wb; u++) begin
				if (wb_valid[u] && (wb_tag[u] == rf_pkg::tag_t'(sel))) begin
					hit = 1'b1;
					merged = merged | wb_res[u];
				end
			end
		end

		// old value kept when nobody writes
		assign dnxt[sel] = hit ? merged : qout[sel];
	end

	// one-hot per valid unit
	always_comb begin
		set_all = '0;
		for (int u = 0; u < rf_pkg::num_wb; u++) begin
			set_all = set_all | (rf_pkg::phy_mask_t'(wb_valid[u]) << wb_tag[u]);
		end
	end

	// x0 writes are dropped
	assign writeb_set = set_all & ~rf_pkg::x0_mask;

endmodule

/* verilog/wb_log.sv */
`timescale 1ns/100ps

module wb_log (
	input  logic              clk,
	input  logic              arst_n,
	// copies written back this cycle
	input  rf_pkg::phy_mask_t writeb_set,
	// rename and commit events
	rename_if.sink            ev,
	// written bit per copy
	output rf_pkg::phy_mask_t done
);

	// copy renamed but result not yet back
	// done is the inverse, so reset leaves every copy written
	rf_pkg::phy_mask_t pend;
	rf_pkg::phy_mask_t rn_clr;
	rf_pkg::phy_mask_t cm_keep;

	// new copy loses its written bit
	assign rn_clr = rf_pkg::phy_mask_t'(ev.rn_fire) << ev.rn_tag;
	// committed copy stays written
	assign cm_keep = rf_pkg::phy_mask_t'(ev.cm_fire) << ev.cm_tag;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend <= '0;
		end else begin
			// rename clear wins over write-back set
			pend <= (pend & ~writeb_set & ~cm_keep) | rn_clr;
		end
	end

	// x0 copies always read as written
	assign done = ~pend | rf_pkg::x0_mask;

endmodule

/* verilog/phy_reg_file.sv */
`timescale 1ns/100ps

module phy_reg_file (
	input  logic          clk,
	input  logic          arst_n,
	// next image from write-back
	input  rf_pkg::xlen_t dnxt [rf_pkg::num_phy],
	// current image
	output rf_pkg::xlen_t qout [rf_pkg::num_phy]
);

	// one 64-bit register per copy
	// copies not written are carried through dnxt unchanged
	for (genvar sel = 0; sel < rf_pkg::num_phy; sel++) begin : g_reg
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				// every copy starts at zero
				qout[sel] <= '0;
			end else begin
				qout[sel] <= dnxt[sel];
			end
		end
	end

endmodule

/* verilog/writeback_top.sv */
`timescale 1ns/100ps

module writeback_top (
	input  logic          clk,
	input  logic          arst_n,
	// alu result
	input  logic          alu_valid,
	input  rf_pkg::tag_t  alu_tag,
	input  rf_pkg::xlen_t alu_res,
	// bru result
	input  logic          bru_valid,
	input  rf_pkg::tag_t  bru_tag,
	input  rf_pkg::xlen_t bru_res,
	// lsu result
	input  logic          lsu_valid,
	input  rf_pkg::tag_t  lsu_tag,
	input  rf_pkg::xlen_t lsu_res,
	// csr result
	input  logic          csr_valid,
	input  rf_pkg::tag_t  csr_tag,
	input  rf_pkg::xlen_t csr_res,
	// mul result
	input  logic          mul_valid,
	input  rf_pkg::tag_t  mul_tag,
	input  rf_pkg::xlen_t mul_res,
	// rename
	input  logic          rn_req,
	input  rf_pkg::arch_t rn_arch,
	output logic          rn_ready,
	output rf_pkg::tag_t  rn_tag,
	// commit
	input  logic          cm_valid,
	input  rf_pkg::arch_t cm_arch,
	// read port, combinational from rd_arch
	input  rf_pkg::arch_t rd_arch,
	output rf_pkg::tag_t  rd_tag,
	output rf_pkg::xlen_t rd_data,
	output logic          rd_done
);

	logic              wb_valid [rf_pkg::num_wb];
	rf_pkg::tag_t      wb_tag   [rf_pkg::num_wb];
	rf_pkg::xlen_t     wb_res   [rf_pkg::num_wb];
	rf_pkg::xlen_t     qout     [rf_pkg::num_phy];
	rf_pkg::xlen_t     dnxt     [rf_pkg::num_phy];
	rf_pkg::phy_mask_t writeb_set;
	rf_pkg::phy_mask_t done;

	rename_if ev ();

	// units packed by slot number
	assign wb_valid[rf_pkg::unit_alu] = alu_valid;
	assign wb_tag[rf_pkg::unit_alu] = alu_tag;
	assign wb_res[rf_pkg::unit_alu] = alu_res;
	assign wb_valid[rf_pkg::unit_bru] = bru_valid;
	assign wb_tag[rf_pkg::unit_bru] = bru_tag;
	assign wb_res[rf_pkg::unit_bru] = bru_res;
	assign wb_valid[rf_pkg::unit_lsu] = lsu_valid;
	assign wb_tag[rf_pkg::unit_lsu] = lsu_tag;
	assign wb_res[rf_pkg::unit_lsu] = lsu_res;
	assign wb_valid[rf_pkg::unit_csr] = csr_valid;
	assign wb_tag[rf_pkg::unit_csr] = csr_tag;
	assign wb_res[rf_pkg::unit_csr] = csr_res;
	assign wb_valid[rf_pkg::unit_mul] = mul_valid;
	assign wb_tag[rf_pkg::unit_mul] = mul_tag;
	assign wb_res[rf_pkg::unit_mul] = mul_res;

	rename_table i_rename_table (
		.clk      (clk),
		.arst_n   (arst_n),
		.rn_req   (rn_req),
		.rn_arch  (rn_arch),
		.rn_ready (rn_ready),
		.rn_tag   (rn_tag),
		.cm_valid (cm_valid),
		.cm_arch  (cm_arch),
		.rd_arch  (rd_arch),
		.rd_tag   (rd_tag),
		.ev       (ev.source)
	);

	write_back i_write_back (
		.wb_valid   (wb_valid),
		.wb_tag     (wb_tag),
		.wb_res     (wb_res),
		.qout       (qout),
		.dnxt       (dnxt),
		.writeb_set (writeb_set)
	);

	wb_log i_wb_log (
		.clk        (clk),
		.arst_n     (arst_n),
		.writeb_set (writeb_set),
		.ev         (ev.sink),
		.done       (done)
	);

	phy_reg_file i_phy_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.dnxt   (dnxt),
		.qout   (qout)
	);

	// newest copy of the register selected by rd_arch
	assign rd_data = qout[rd_tag];
	assign rd_done = done[rd_tag];

endmodule

/* testbench/writeback_properties.sv */
`timescale 1ns/100ps

module writeback_properties (
	input logic          clk,
	input logic          arst_n,
	// packed unit results inside the top level
	input logic          wb_valid [rf_pkg::num_wb],
	input rf_pkg::tag_t  wb_tag   [rf_pkg::num_wb],
	// rename port
	input logic          rn_req,
	input rf_pkg::arch_t rn_arch,
	input logic          rn_ready,
	input rf_pkg::tag_t  rn_tag,
	// read port
	input rf_pkg::arch_t rd_arch,
	input logic          rd_done
);

	logic tag_clash;

	// any pair of valid units on one tag
	always_comb begin
		tag_clash = 1'b0;
		for (int i = 0; i < rf_pkg::num_wb; i++) begin
			for (int j = i + 1; j < rf_pkg::num_wb; j++) begin
				if (wb_valid[i] && wb_valid[j] && (wb_tag[i] == wb_tag[j])) begin
					tag_clash = 1'b1;
				end
			end
		end
	end

	a_unique_tag: assert property (@(posedge clk) disable iff (!arst_n) !tag_clash)
		else $error("two write-back units carry the same tag");

	// x0 tag is {0, copy 0}, so the whole tag is zero
	a_x0_copy: assert property (@(posedge clk) disable iff (!arst_n)
		(rn_arch == '0) |-> (rn_tag == '0))
		else $error("rename of x0 shows a copy other than 0");

	// with rd_arch held, only a rename of that register drops done
	a_done_fall: assert property (@(posedge clk) disable iff (!arst_n)
		($fell(rd_done) && $stable(rd_arch)) |->
		$past(rn_req && rn_ready && (rn_arch == rd_arch) && (rn_arch != '0)))
		else $error("rd_done fell without a rename of the read register");

endmodule

/* testbench/tb_writeback.sv */
`timescale 1ns/100ps

module tb_writeback;

	localparam int period = 8;
	// 15 unit columns, 5 control inputs, 5 expected outputs
	localparam int num_cols = 25;
	localparam int max_steps = 128;

	logic          clk;
	logic          arst_n = 1'b0;
	logic          alu_valid = 1'b0;
	rf_pkg::tag_t  alu_tag = '0;
	rf_pkg::xlen_t alu_res = '0;
	logic          bru_valid = 1'b0;
	rf_pkg::tag_t  bru_tag = '0;
	rf_pkg::xlen_t bru_res = '0;
	logic          lsu_valid = 1'b0;
	rf_pkg::tag_t  lsu_tag = '0;
	rf_pkg::xlen_t lsu_res = '0;
	logic          csr_valid = 1'b0;
	rf_pkg::tag_t  csr_tag = '0;
	rf_pkg::xlen_t csr_res = '0;
	logic          mul_valid = 1'b0;
	rf_pkg::tag_t  mul_tag = '0;
	rf_pkg::xlen_t mul_res = '0;
	logic          rn_req = 1'b0;
	rf_pkg::arch_t rn_arch = '0;
	logic          rn_ready;
	rf_pkg::tag_t  rn_tag;
	logic          cm_valid = 1'b0;
	rf_pkg::arch_t cm_arch = '0;
	rf_pkg::arch_t rd_arch = '0;
	rf_pkg::tag_t  rd_tag;
	rf_pkg::xlen_t rd_data;
	logic          rd_done;

	// trace rows with one hex value per column
	logic [63:0] steps [max_steps][num_cols];
	int          n_steps = 0;
	int          cur_step = 0;
	int          cycles = 0;
	// zero until the trace is loaded
	int          limit = 0;

	writeback_top i_dut (.*);

	bind writeback_top writeback_properties i_props (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_valid (wb_valid),
		.wb_tag   (wb_tag),
		.rn_req   (rn_req),
		.rn_arch  (rn_arch),
		.rn_ready (rn_ready),
		.rn_tag   (rn_tag),
		.rd_arch  (rd_arch),
		.rd_done  (rd_done)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	// trace length plus margin for reset and drain
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((limit > 0) && (cycles >= limit)) begin
			$display("Timeout: trace not finished within %0d cycles", limit);
			abort_run();
		end
	end

	task automatic load_trace();
		int          fd;
		int          code;
		string       line;
		logic [63:0] c [num_cols];
		fd = $fopen("testbench/writeback_trace.txt", "r");
		if (fd == 0) begin
			$display("Trace file testbench/writeback_trace.txt could not be opened");
			abort_run();
		end
		while ($fgets(line, fd) > 0) begin
			// comment lines
			if ((line.len() == 0) || (line[0] == "#")) begin
				continue;
			end
			code = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
				c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], c[18], c[19],
				c[20], c[21], c[22], c[23], c[24]);
			// blank line
			if (code <= 0) begin
				continue;
			end
			if ((code != num_cols) || (n_steps >= max_steps)) begin
				$display("Trace line %0d is malformed or the trace is too long", n_steps);
				abort_run();
			end
			for (int k = 0; k < num_cols; k++) begin
				steps[n_steps][k] = c[k];
			end
			n_steps++;
		end
		$fclose(fd);
	endtask

	// unit u sits at columns 3u, 3u+1, 3u+2
	task automatic drive_step(input int s);
		alu_valid = steps[s][0][0];
		alu_tag = steps[s][1][6:0];
		alu_res = steps[s][2];
		bru_valid = steps[s][3][0];
		bru_tag = steps[s][4][6:0];
		bru_res = steps[s][5];
		lsu_valid = steps[s][6][0];
		lsu_tag = steps[s][7][6:0];
		lsu_res = steps[s][8];
		csr_valid = steps[s][9][0];
		csr_tag = steps[s][10][6:0];
		csr_res = steps[s][11];
		mul_valid = steps[s][12][0];
		mul_tag = steps[s][13][6:0];
		mul_res = steps[s][14];
		rn_req = steps[s][15][0];
		rn_arch = steps[s][16][4:0];
		cm_valid = steps[s][17][0];
		cm_arch = steps[s][18][4:0];
		rd_arch = steps[s][19][4:0];
	endtask

	task automatic check_tag(input string name, input rf_pkg::tag_t got,
		input rf_pkg::tag_t exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h at trace step %0d", name, got, exp, cur_step);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input rf_pkg::xlen_t got,
		input rf_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h at trace step %0d", name, got, exp, cur_step);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h at trace step %0d", name, got, exp, cur_step);
			abort_run();
		end
	endtask

	initial begin
		load_trace();
		limit = n_steps + 20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int s = 0; s < n_steps; s++) begin
			cur_step = s;
			drive_step(s);
			// sample just before the next falling edge
			@(posedge clk);
			#(period / 2 - 1);
			check_flag("rn_ready", rn_ready, steps[s][20][0]);
			check_tag("rn_tag", rn_tag, steps[s][21][6:0]);
			check_tag("rd_tag", rd_tag, steps[s][22][6:0]);
			check_data("rd_data", rd_data, steps[s][23]);
			check_flag("rd_done", rd_done, steps[s][24][0]);
			@(negedge clk);
		end
		$display("No errors");
		$finish;
	end

endmodule

/* writeback.f */
verilog/rf_pkg.sv
verilog/rename_if.sv
verilog/rename_table.sv
verilog/write_back.sv
verilog/wb_log.sv
verilog/phy_reg_file.sv
verilog/writeback_top.sv
testbench/writeback_properties.sv
testbench/tb_writeback.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_writeback -f writeback.f -o tb_writeback
	out=$$(./obj_dir/tb_writeback); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

/* testbench/writeback_trace.txt */
# alu bru lsu csr mul as valid tag res, rn_req rn_arch, cm_valid cm_arch, rd_arch
# expected after the edge: rn_ready rn_tag rd_tag rd_data rd_done
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  00   1 00 00 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 01  0 00  01   1 05 04 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 05  0 00  05   1 15 14 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 1f  0 00  1f   1 7d 7c 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 01  0 00  01   1 06 05 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 01  0 00  01   1 06 05 0 0
1 05 1234abcd  0 00 0  0 00 0  0 00 0  0 00 0  0 01  0 00  01   1 06 05 1234abcd 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 02  0 00  02   1 0a 09 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 03  0 00  03   1 0e 0d 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 04  0 00  04   1 12 11 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 05  0 00  05   1 16 15 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 06  0 00  06   1 1a 19 0 0
1 09 a1  1 0d b2b2  1 11 deadbeefcafef00d  1 15 c4  1 19 5555aaaa  0 00  0 00  02   1 00 09 a1 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  03   1 00 0d b2b2 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  04   1 00 11 deadbeefcafef00d 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  05   1 00 15 c4 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  06   1 00 19 5555aaaa 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  0 00  01   1 00 05 1234abcd 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 01  0 00  01   1 07 06 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 01  0 00  01   0 04 07 0 0
1 07 77  0 00 0  0 00 0  0 00 0  0 00 0  1 01  0 00  01   0 04 07 77 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 01  1 01  01   1 04 07 77 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 01  0 00  01   0 05 04 0 0
0 00 0  0 00 0  1 04 4444  0 00 0  0 00 0  0 01  0 00  01   0 05 04 4444 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 02  1 02  02   1 0b 0a 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 02  0 00  02   1 08 0b 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 02  1 02  02   1 09 08 0 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 02  0 00  02   0 0a 09 a1 0
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 00  0 00  00   1 00 00 0 1
1 00 ffff  1 03 3333  0 00 0  0 00 0  0 00 0  0 00  0 00  00   1 00 00 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  1 00  1 00  00   1 00 00 0 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 05  0 00  05   1 16 15 c4 1
0 00 0  0 00 0  0 00 0  0 00 0  0 00 0  0 00  1 07  07   1 00 1c 0 1
